/* mac_pkg.sv */
/*
  Shared sizes, opcodes and instruction formats for the multiply-add core.
  Both instruction views keep the opcode and rd in the same bit positions.
  Any opcode not listed in opcode_e is treated as illegal by the decoder.
*/

package mac_pkg;

   // register file geometry
   localparam int data_width_lp     = 32;
   localparam int reg_els_lp        = 32;
   localparam int reg_addr_width_lp = $clog2(reg_els_lp);
   localparam int rf_read_ports_lp  = 3;

   // instruction word layout
   localparam int instr_width_lp    = 32;
   localparam int opcode_width_lp   = 5;
   localparam int imm_width_lp      = instr_width_lp - opcode_width_lp - reg_addr_width_lp;
   localparam int r4_pad_width_lp   = instr_width_lp - opcode_width_lp
                                      - 4 * reg_addr_width_lp;

   // codes outside this set raise illegal_o
   typedef enum logic [opcode_width_lp-1:0]
   {
      op_madd = 5'h01,
      op_msub = 5'h02,
      op_li   = 5'h03
   } opcode_e;

   // four register form, used by madd and msub
   typedef struct packed
   {
      opcode_e                      opcode;
      logic [reg_addr_width_lp-1:0] rd;
      logic [reg_addr_width_lp-1:0] rs1;
      logic [reg_addr_width_lp-1:0] rs2;
      logic [reg_addr_width_lp-1:0] rs3;
      logic [r4_pad_width_lp-1:0]   unused;
   } instr_r4_s;

   // immediate form, used by li
   typedef struct packed
   {
      opcode_e                      opcode;
      logic [reg_addr_width_lp-1:0] rd;
      logic [imm_width_lp-1:0]      imm;
   } instr_imm_s;

   // one word, two decodings selected by the opcode
   typedef union packed
   {
      instr_r4_s  r4;
      instr_imm_s imm;
   } mac_instr_u;

endpackage

/* mac_decode.sv */
/*
  Instruction decoder. Accepts one word on every edge where instr_v_i is high.
  Read strobes are combinational from the incoming word; the decoded op,
  rd and immediate reach execute one cycle later. No back-pressure.
*/

`timescale 1ns/1ns

module mac_decode
   import mac_pkg::*;
(
   input  logic                         clk_i,
   input  logic                         rst_n_i,

   input  logic                         instr_v_i,
   input  mac_instr_u                   instr_i,

   output logic                         r0_v_o,
   output logic [reg_addr_width_lp-1:0] r0_addr_o,
   output logic                         r1_v_o,
   output logic [reg_addr_width_lp-1:0] r1_addr_o,
   output logic                         r2_v_o,
   output logic [reg_addr_width_lp-1:0] r2_addr_o,

   output logic                         dec_v_o,
   output opcode_e                      dec_op_o,
   output logic [reg_addr_width_lp-1:0] dec_rd_o,
   output logic [imm_width_lp-1:0]      dec_imm_o,

   output logic                         illegal_o
);

   logic is_mac;
   logic is_li;
   logic legal;
   logic accept;

   // opcode sits at the same place in both views
   always_comb
   begin
      is_mac = 1'b0;
      is_li  = 1'b0;
      case (instr_i.r4.opcode)
         op_madd, op_msub:
         begin
            is_mac = 1'b1;
         end
         op_li:
         begin
            is_li = 1'b1;
         end
         default:
         begin
            is_mac = 1'b0;
            is_li  = 1'b0;
         end
      endcase
   end

   assign legal  = is_mac | is_li;
   assign accept = instr_v_i & legal;

   // only the multiply-add forms touch the register file
   assign r0_v_o    = instr_v_i & is_mac;
   assign r1_v_o    = instr_v_i & is_mac;
   assign r2_v_o    = instr_v_i & is_mac;
   assign r0_addr_o = instr_i.r4.rs1;
   assign r1_addr_o = instr_i.r4.rs2;
   assign r2_addr_o = instr_i.r4.rs3;

   // control: one pulse per accepted word, either valid or illegal
   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         dec_v_o   <= 1'b0;
         illegal_o <= 1'b0;
      end
      else
      begin
         dec_v_o   <= accept;
         illegal_o <= instr_v_i & ~legal;
      end
   end

   // payload for execute, only loaded for legal words
   // rd shares its bits in both views
   always_ff @(posedge clk_i)
   begin
      if (accept)
      begin
         dec_op_o  <= instr_i.r4.opcode;
         dec_rd_o  <= instr_i.r4.rd;
         dec_imm_o <= instr_i.imm.imm;
      end
   end

endmodule

/* regfile_3r1w_sync.sv */
/*
  Register file with three synchronous read ports and one write port.
  Write-first: a read of the address written at the same edge returns the
  new data. A port keeps its last data while its valid is low.
  Storage is not reset; only the read data registers are cleared.
*/

`timescale 1ns/1ns

module regfile_3r1w_sync
   import mac_pkg::*;
(
   input  logic                         clk_i,
   input  logic                         rst_n_i,

   input  logic                         w_v_i,
   input  logic [reg_addr_width_lp-1:0] w_addr_i,
   input  logic [data_width_lp-1:0]     w_data_i,

   input  logic                         r0_v_i,
   input  logic [reg_addr_width_lp-1:0] r0_addr_i,
   output logic [data_width_lp-1:0]     r0_data_o,

   input  logic                         r1_v_i,
   input  logic [reg_addr_width_lp-1:0] r1_addr_i,
   output logic [data_width_lp-1:0]     r1_data_o,

   input  logic                         r2_v_i,
   input  logic [reg_addr_width_lp-1:0] r2_addr_i,
   output logic [data_width_lp-1:0]     r2_data_o
);

   logic [data_width_lp-1:0]     mem_r [reg_els_lp];

   logic [rf_read_ports_lp-1:0]  rd_v;
   logic [reg_addr_width_lp-1:0] rd_addr [rf_read_ports_lp];
   logic [data_width_lp-1:0]     rd_data_r [rf_read_ports_lp];

   // gather the loose ports so all read ports share one description
   assign rd_v       = {r2_v_i, r1_v_i, r0_v_i};
   assign rd_addr[0] = r0_addr_i;
   assign rd_addr[1] = r1_addr_i;
   assign rd_addr[2] = r2_addr_i;

   assign r0_data_o  = rd_data_r[0];
   assign r1_data_o  = rd_data_r[1];
   assign r2_data_o  = rd_data_r[2];

   always_ff @(posedge clk_i)
   begin
      if (w_v_i)
      begin
         mem_r[w_addr_i] <= w_data_i;
      end
   end

   for (genvar k = 0; k < rf_read_ports_lp; k++)
   begin : g_rd
      logic bypass;

      // same-edge write to this address wins over the stored word
      assign bypass = w_v_i && (w_addr_i == rd_addr[k]);

      always_ff @(posedge clk_i)
      begin
         if (!rst_n_i)
         begin
            rd_data_r[k] <= '0;
         end
         else if (rd_v[k])
         begin
            rd_data_r[k] <= bypass ? w_data_i : mem_r[rd_addr[k]];
         end
      end
   end

endmodule

/* mac_execute.sv */
/*
  Execute stage. Computes rs3 +/- rs1*rs2 (low 32 bits, wrapping) or a
  sign-extended immediate. Write-back is combinational in the dec_v cycle;
  the result outputs are the same value registered one cycle later.
*/

`timescale 1ns/1ns

module mac_execute
   import mac_pkg::*;
(
   input  logic                         clk_i,
   input  logic                         rst_n_i,

   input  logic                         dec_v_i,
   input  opcode_e                      dec_op_i,
   input  logic [reg_addr_width_lp-1:0] dec_rd_i,
   input  logic [imm_width_lp-1:0]      dec_imm_i,

   input  logic [data_width_lp-1:0]     r0_data_i,
   input  logic [data_width_lp-1:0]     r1_data_i,
   input  logic [data_width_lp-1:0]     r2_data_i,

   output logic                         w_v_o,
   output logic [reg_addr_width_lp-1:0] w_addr_o,
   output logic [data_width_lp-1:0]     w_data_o,

   output logic                         result_v_o,
   output logic [reg_addr_width_lp-1:0] result_rd_o,
   output logic [data_width_lp-1:0]     result_o
);

   logic [data_width_lp-1:0] product;
   logic [data_width_lp-1:0] imm_ext;
   logic [data_width_lp-1:0] alu_result;

   // 32-bit context keeps only the low half of the product
   assign product = r0_data_i * r1_data_i;

   assign imm_ext = {{(data_width_lp - imm_width_lp){dec_imm_i[imm_width_lp-1]}},
                     dec_imm_i};

   always_comb
   begin
      case (dec_op_i)
         op_madd:
         begin
            alu_result = r2_data_i + product;
         end
         op_msub:
         begin
            alu_result = r2_data_i - product;
         end
         op_li:
         begin
            alu_result = imm_ext;
         end
         default:
         begin
            // decoder never forwards other codes
            alu_result = '0;
         end
      endcase
   end

   // write-back lands at the edge closing the dec_v cycle
   assign w_v_o    = dec_v_i;
   assign w_addr_o = dec_rd_i;
   assign w_data_o = alu_result;

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         result_v_o  <= 1'b0;
         result_rd_o <= '0;
         result_o    <= '0;
      end
      else
      begin
         result_v_o <= dec_v_i;
         if (dec_v_i)
         begin
            result_rd_o <= dec_rd_i;
            result_o    <= alu_result;
         end
      end
   end

endmodule

/* mac_core_top.sv */
/*
  Multiply-add core: decode, 3r1w register file and execute.
  One instruction per cycle, results two cycles after issue, no stalls.
  Register contents are undefined until written by the program.
*/

`timescale 1ns/1ns

module mac_core_top
   import mac_pkg::*;
(
   input  logic                         clk_i,
   input  logic                         rst_n_i,

   input  logic                         instr_v_i,
   input  mac_instr_u                   instr_i,

   output logic                         result_v_o,
   output logic [reg_addr_width_lp-1:0] result_rd_o,
   output logic [data_width_lp-1:0]     result_o,
   output logic                         illegal_o
);

   // decode to register file
   logic                         r0_v;
   logic [reg_addr_width_lp-1:0] r0_addr;
   logic                         r1_v;
   logic [reg_addr_width_lp-1:0] r1_addr;
   logic                         r2_v;
   logic [reg_addr_width_lp-1:0] r2_addr;

   // decode to execute
   logic                         dec_v;
   opcode_e                      dec_op;
   logic [reg_addr_width_lp-1:0] dec_rd;
   logic [imm_width_lp-1:0]      dec_imm;

   // register file to execute
   logic [data_width_lp-1:0]     r0_data;
   logic [data_width_lp-1:0]     r1_data;
   logic [data_width_lp-1:0]     r2_data;

   // write-back
   logic                         w_v;
   logic [reg_addr_width_lp-1:0] w_addr;
   logic [data_width_lp-1:0]     w_data;

   mac_decode u_decode
   (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .instr_v_i (instr_v_i),
      .instr_i   (instr_i),
      .r0_v_o    (r0_v),
      .r0_addr_o (r0_addr),
      .r1_v_o    (r1_v),
      .r1_addr_o (r1_addr),
      .r2_v_o    (r2_v),
      .r2_addr_o (r2_addr),
      .dec_v_o   (dec_v),
      .dec_op_o  (dec_op),
      .dec_rd_o  (dec_rd),
      .dec_imm_o (dec_imm),
      .illegal_o (illegal_o)
   );

   regfile_3r1w_sync u_regfile
   (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .w_v_i     (w_v),
      .w_addr_i  (w_addr),
      .w_data_i  (w_data),
      .r0_v_i    (r0_v),
      .r0_addr_i (r0_addr),
      .r0_data_o (r0_data),
      .r1_v_i    (r1_v),
      .r1_addr_i (r1_addr),
      .r1_data_o (r1_data),
      .r2_v_i    (r2_v),
      .r2_addr_i (r2_addr),
      .r2_data_o (r2_data)
   );

   mac_execute u_execute
   (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .dec_v_i     (dec_v),
      .dec_op_i    (dec_op),
      .dec_rd_i    (dec_rd),
      .dec_imm_i   (dec_imm),
      .r0_data_i   (r0_data),
      .r1_data_i   (r1_data),
      .r2_data_i   (r2_data),
      .w_v_o       (w_v),
      .w_addr_o    (w_addr),
      .w_data_o    (w_data),
      .result_v_o  (result_v_o),
      .result_rd_o (result_rd_o),
      .result_o    (result_o)
   );

endmodule

/* tb_mac_core.sv */
/*
  Self-checking testbench for mac_core_top. A register model predicts each
  result at issue time and concurrent assertions compare the result port.
  The li test writes all 32 registers before any test reads them.
*/

`timescale 1ns/1ns

module tb_mac_core
   import mac_pkg::*;
();

   localparam int half_period_lp  = 20;
   localparam int reset_cycles_lp = 8;
   localparam int n_li_lp         = 32;
   localparam int n_mac_lp        = 60;
   localparam int n_chain_lp      = 40;
   localparam int n_mixed_lp      = 40;
   localparam int n_random_lp     = 400;
   localparam int gap_max_lp      = 3;
   // mixed test may add one read per word; idle and drain cycles sit in the margin
   localparam int budget_cycles_lp = reset_cycles_lp + n_li_lp + n_mac_lp + n_chain_lp
                                     + 2 * n_mixed_lp + n_random_lp * (1 + gap_max_lp) + 200;
   localparam int exp_width_lp    = reg_addr_width_lp + data_width_lp;

   logic                         clk;
   logic                         rst_n;
   logic                         instr_v;
   mac_instr_u                   instr;
   logic                         result_v;
   logic [reg_addr_width_lp-1:0] result_rd;
   logic [data_width_lp-1:0]     result;
   logic                         illegal;

   logic [data_width_lp-1:0]     model [reg_els_lp];
   logic [exp_width_lp-1:0]      exp_q [$];
   logic [exp_width_lp-1:0]      exp_head;
   logic                         exp_avail;
   logic                         in_legal;
   logic                         in_illegal;
   logic [1:0]                   legal_hist;
   logic [1:0]                   illegal_hist;
   logic                         checks_on;
   logic [imm_width_lp-1:0]      imm_bounds [5];
   string                        test_name;
   int                           errors;
   int                           issued;
   int                           results_seen;
   int                           tests_run;
   int                           test_err0;
   int                           test_iss0;

   always #(half_period_lp) clk = ~clk;

   mac_core_top u_dut
   (
      .clk_i       (clk),
      .rst_n_i     (rst_n),
      .instr_v_i   (instr_v),
      .instr_i     (instr),
      .result_v_o  (result_v),
      .result_rd_o (result_rd),
      .result_o    (result),
      .illegal_o   (illegal)
   );

   assign in_legal   = instr_v && (instr.r4.opcode inside {op_madd, op_msub, op_li});
   assign in_illegal = instr_v && !(instr.r4.opcode inside {op_madd, op_msub, op_li});

   // issue history and expected-result queue, all moved on the clock edge
   always @(posedge clk)
   begin
      checks_on    <= checks_on | ~rst_n;
      legal_hist   <= {legal_hist[0], in_legal};
      illegal_hist <= {illegal_hist[0], in_illegal};
      if (result_v && exp_q.size() != 0)
      begin
         void'(exp_q.pop_front());
         results_seen++;
      end
      exp_avail <= (exp_q.size() != 0);
      if (exp_q.size() != 0)
      begin
         exp_head <= exp_q[0];
      end
   end

   result_check: assert property (@(posedge clk)
      (checks_on && result_v) |-> (exp_avail
         && result_rd == exp_head[data_width_lp +: reg_addr_width_lp]
         && result == exp_head[data_width_lp-1:0]))
   else
   begin
      errors++;
      if (!$sampled(exp_avail))
      begin
         $display("Error in %s: result for rd %0d with no instruction outstanding",
                  test_name, $sampled(result_rd));
      end
      else
      begin
         $display("Mismatch %s: expected rd %0d value %08h, actual rd %0d value %08h",
                  test_name, $sampled(exp_head[data_width_lp +: reg_addr_width_lp]),
                  $sampled(exp_head[data_width_lp-1:0]), $sampled(result_rd),
                  $sampled(result));
      end
   end

   // illegal pulse one cycle after the accepting edge, result two cycles after
   pulse_check: assert property (@(posedge clk)
      checks_on |-> (illegal == illegal_hist[0] && result_v == legal_hist[1]))
   else
   begin
      errors++;
      $display("Mismatch %s: expected illegal %0b result_v %0b, actual illegal %0b result_v %0b",
               test_name, $sampled(illegal_hist[0]), $sampled(legal_hist[1]),
               $sampled(illegal), $sampled(result_v));
   end

   function automatic logic [instr_width_lp-1:0] r4_word(input logic [4:0] op,
      input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2,
      input logic [4:0] rs3);
      return {op, rd, rs1, rs2, rs3, 7'b0};
   endfunction

   function automatic logic [instr_width_lp-1:0] li_word(input logic [4:0] rd,
      input logic [imm_width_lp-1:0] imm);
      return {5'(op_li), rd, imm};
   endfunction

   function automatic logic [4:0] rand_reg();
      return 5'($urandom);
   endfunction

   function automatic logic [4:0] rand_mac_op();
      return ($urandom % 2 == 0) ? 5'(op_madd) : 5'(op_msub);
   endfunction

   // maps 0..28 onto every code outside 1..3
   function automatic logic [4:0] rand_illegal_op();
      logic [4:0] op;
      op = 5'($urandom % 29);
      if (op != 5'd0)
      begin
         op = op + 5'd3;
      end
      return op;
   endfunction

   function automatic logic [instr_width_lp-1:0] random_word();
      int sel;
      sel = int'($urandom % 8);
      if (sel == 0)
      begin
         return r4_word(rand_illegal_op(), rand_reg(), rand_reg(), rand_reg(), rand_reg());
      end
      if (sel < 3)
      begin
         return li_word(rand_reg(), 22'($urandom));
      end
      return r4_word(rand_mac_op(), rand_reg(), rand_reg(), rand_reg(), rand_reg());
   endfunction

   // updates the model in issue order and drives the word for one cycle
   task automatic issue(input logic [instr_width_lp-1:0] word);
      logic [4:0]                 op;
      logic [4:0]                 rd;
      logic [2*data_width_lp-1:0] prod;
      logic [data_width_lp-1:0]   val;
      logic                       legal;
      op    = word[31:27];
      rd    = word[26:22];
      prod  = {32'b0, model[word[21:17]]} * {32'b0, model[word[16:12]]};
      legal = 1'b1;
      val   = '0;
      case (op)
         5'(op_madd): val = model[word[11:7]] + prod[31:0];
         5'(op_msub): val = model[word[11:7]] - prod[31:0];
         5'(op_li):   val = {{10{word[21]}}, word[21:0]};
         default:     legal = 1'b0;
      endcase
      @(posedge clk);
      instr_v <= 1'b1;
      instr   <= word;
      issued++;
      if (legal)
      begin
         model[rd] = val;
         exp_q.push_back({rd, val});
      end
   endtask

   task automatic idle(input int n);
      repeat (n)
      begin
         @(posedge clk);
         instr_v <= 1'b0;
      end
   endtask

   task automatic start_test(input string name);
      test_name = name;
      test_err0 = errors;
      test_iss0 = issued;
   endtask

   task automatic end_test();
      idle(1);
      while (exp_q.size() != 0)
      begin
         idle(1);
      end
      idle(3);
      tests_run++;
      $display("test %-14s done: %0d instructions, %0d errors",
               test_name, issued - test_iss0, errors - test_err0);
   endtask

   initial
   begin
      logic [4:0] rd;
      logic [4:0] prev;
      int         gap;
      void'($urandom(48419));
      clk          = 1'b0;
      rst_n        = 1'b0;
      instr_v      = 1'b0;
      instr        = '0;
      exp_avail    = 1'b0;
      exp_head     = '0;
      legal_hist   = '0;
      illegal_hist = '0;
      checks_on    = 1'b0;
      errors       = 0;
      issued       = 0;
      results_seen = 0;
      tests_run    = 0;
      imm_bounds   = '{22'h000000, 22'h000001, 22'h1fffff, 22'h200000, 22'h3fffff};
      repeat (reset_cycles_lp) @(posedge clk);
      rst_n <= 1'b1;

      start_test("reset_idle");
      idle(16);
      assert (result == '0 && result_rd == '0)
      else
      begin
         errors++;
         $display("Mismatch %s: expected rd 0 value 00000000, actual rd %0d value %08h",
                  test_name, result_rd, result);
      end
      end_test();

      start_test("load_imm");
      for (int r = 0; r < n_li_lp; r++)
      begin
         issue(li_word(5'(r), (r < 5) ? imm_bounds[r] : 22'($urandom)));
      end
      end_test();

      start_test("mac_random");
      for (int i = 0; i < n_mac_lp; i++)
      begin
         issue(r4_word(rand_mac_op(), rand_reg(), rand_reg(), rand_reg(), rand_reg()));
      end
      end_test();

      // each word reads the destination of the word just before it
      start_test("dep_chain");
      prev = rand_reg();
      for (int i = 0; i < n_chain_lp; i++)
      begin
         rd = rand_reg();
         case (i % 4)
            0: issue(r4_word(rand_mac_op(), rd, prev, prev, prev));
            1: issue(r4_word(rand_mac_op(), rd, prev, rand_reg(), rand_reg()));
            2: issue(r4_word(rand_mac_op(), rd, rand_reg(), prev, rand_reg()));
            default: issue(r4_word(rand_mac_op(), rd, rand_reg(), rand_reg(), prev));
         endcase
         prev = rd;
      end
      end_test();

      // a read of the illegal word's rd right behind it exposes a stray write
      start_test("illegal_mix");
      for (int i = 0; i < n_mixed_lp; i++)
      begin
         if ($urandom % 4 == 0)
         begin
            rd = rand_reg();
            issue(r4_word(rand_illegal_op(), rd, rand_reg(), rand_reg(), rand_reg()));
            issue(r4_word(op_madd, rand_reg(), rd, rd, rd));
         end
         else
         begin
            issue(r4_word(rand_mac_op(), rand_reg(), rand_reg(), rand_reg(), rand_reg()));
         end
      end
      end_test();

      start_test("random_stream");
      for (int i = 0; i < n_random_lp; i++)
      begin
         issue(random_word());
         gap = int'($urandom % (gap_max_lp + 1));
         if (gap != 0)
         begin
            idle(gap);
         end
      end
      end_test();

      $display("summary: %0d tests, %0d instructions, %0d results checked, %0d errors",
               tests_run, issued, results_seen, errors);
      if (errors == 0)
      begin
         $display(">>> PASS");
      end
      else
      begin
         $display(">>> FAIL");
      end
      $finish;
   end

   initial
   begin
      #(budget_cycles_lp * 2 * half_period_lp);
      $display("timeout: the run did not finish within %0d clock cycles", budget_cycles_lp);
      $display(">>> FAIL");
      $finish;
   end

endmodule

/* all.f */
mac_pkg.sv
mac_decode.sv
regfile_3r1w_sync.sv
mac_execute.sv
mac_core_top.sv
tb_mac_core.sv

/* Makefile */
# Verilator flow for the multiply-add core
# every variable below can be overridden, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_mac_core
RTL_TOP   ?= mac_core_top
FILELIST  ?= all.f
RTL_FILES ?= mac_pkg.sv mac_decode.sv regfile_3r1w_sync.sv mac_execute.sv mac_core_top.sv
TB_FILES  ?= tb_mac_core.sv
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_FILES)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build: $(SIM_BIN)

$(SIM_BIN): $(RTL_FILES) $(TB_FILES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

# the log decides the outcome, not the exit code of the binary
sim: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF '>>> PASS' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
